// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mips_cpu_bus_tb
FLIST     := flist.f
BUILD_DIR := obj_dir
PASS_MSG  := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== flist.f ====
+incdir+source
source/mips_pkg.sv
source/mips_reg_file.sv
source/mips_alu.sv
source/mips_cpu_bus.sv
testbench/mips_cpu_bus_tb.sv

// ==== source/mips_alu.sv ====
// MIPS ALU covering add, subtract, logic, compare and shift operations.

`timescale 1ns/10ps

module mips_alu import mips_pkg::*; (
    input  alu_op_t    op,
    input  word_t      x,
    input  word_t      y,
    input  logic [4:0] shamt,
    output word_t      result,
    output logic       zero
);

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = x + y;
            end
            ALU_SUB: begin
                result = x - y;   // Also drives the branch compare.
            end
            ALU_AND: begin
                result = x & y;
            end
            ALU_OR: begin
                result = x | y;
            end
            ALU_XOR: begin
                result = x ^ y;
            end
            ALU_NOR: begin
                result = ~(x | y);
            end
            ALU_SLT: begin
                result = {31'd0, $signed(x) < $signed(y)};
            end
            ALU_SLTU: begin
                result = {31'd0, x < y};
            end
            // Shifts act on the rt operand.
            ALU_SLL: begin
                result = y << shamt;
            end
            ALU_SRL: begin
                result = y >> shamt;
            end
            ALU_SRA: begin
                result = $signed(y) >>> shamt;
            end
            ALU_LUI: begin
                result = {y[15:0], 16'h0000};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== source/mips_cpu_bus.sv ====
// Multicycle MIPS32 core acting as an Avalon memory-mapped bus master.

`timescale 1ns/10ps
`include "mips_defs.svh"

module mips_cpu_bus import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    output logic       active,
    output word_t      register_v0,
    output word_t      address,
    output logic       write,
    output logic       read,
    input  logic       waitrequest,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  word_t      readdata
);

    state_t     state;
    word_t      pc, pc_plus4, pc_next, branch_target;
    word_t      ir, effective_ir;
    opcode_t    opcode;
    funct_t     funct;
    reg_idx_t   rs, rt, rd;
    logic [4:0] shamt;
    logic [15:0] imm;
    logic [25:0] target;
    word_t      imm_ext;
    word_t      rs_val, rt_val;
    word_t      alu_y, alu_result;
    alu_op_t    alu_op;
    logic       alu_zero;
    logic       exec_write;     // EXECUTE writes a result to rd.
    logic       rf_write_en;
    word_t      rf_data_in;
    logic       is_load, is_store;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        // In EXECUTE the fetched word is still on the bus.
        effective_ir = (state == STATE_EXECUTE) ? readdata : ir;
        opcode = opcode_t'(effective_ir[31:26]);
        rs     = effective_ir[25:21];
        rt     = effective_ir[20:16];
        rd     = (opcode == OPCODE_RTYPE) ? effective_ir[15:11] : rt;
        shamt  = effective_ir[10:6];
        funct  = funct_t'(effective_ir[5:0]);
        imm    = effective_ir[15:0];
        target = effective_ir[25:0];
        case (opcode)
            OPCODE_ANDI, OPCODE_ORI, OPCODE_XORI: imm_ext = {16'h0000, imm};
            default:                              imm_ext = {{16{imm[15]}}, imm};
        endcase
    end

    always_comb begin
        alu_op     = ALU_ADD;
        alu_y      = imm_ext;
        exec_write = 1'b0;
        case (opcode)
            OPCODE_RTYPE: begin
                alu_y      = rt_val;
                exec_write = 1'b1;
                case (funct)
                    FUNCT_ADDU: alu_op = ALU_ADD;
                    FUNCT_SUBU: alu_op = ALU_SUB;
                    FUNCT_AND:  alu_op = ALU_AND;
                    FUNCT_OR:   alu_op = ALU_OR;
                    FUNCT_XOR:  alu_op = ALU_XOR;
                    FUNCT_SLT:  alu_op = ALU_SLT;
                    FUNCT_SLTU: alu_op = ALU_SLTU;
                    FUNCT_SLL:  alu_op = ALU_SLL;
                    FUNCT_SRL:  alu_op = ALU_SRL;
                    FUNCT_SRA:  alu_op = ALU_SRA;
                    default:    exec_write = 1'b0;   // JR and unknowns.
                endcase
            end
            OPCODE_BEQ, OPCODE_BNE: begin
                alu_op = ALU_SUB;
                alu_y  = rt_val;
            end
            OPCODE_ADDIU: begin alu_op = ALU_ADD;  exec_write = 1'b1; end
            OPCODE_SLTIU: begin alu_op = ALU_SLTU; exec_write = 1'b1; end
            OPCODE_ANDI:  begin alu_op = ALU_AND;  exec_write = 1'b1; end
            OPCODE_ORI:   begin alu_op = ALU_OR;   exec_write = 1'b1; end
            OPCODE_XORI:  begin alu_op = ALU_XOR;  exec_write = 1'b1; end
            OPCODE_LUI:   begin alu_op = ALU_LUI;  exec_write = 1'b1; end
            default: ;   // LW/SW add base and offset; the rest are no-ops.
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next PC
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        pc_plus4      = pc + 32'd4;
        branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
        pc_next       = pc_plus4;
        case (opcode)
            OPCODE_BEQ:   if (alu_zero)  pc_next = branch_target;
            OPCODE_BNE:   if (!alu_zero) pc_next = branch_target;
            OPCODE_J:     pc_next = {pc_plus4[31:28], target, 2'b00};
            OPCODE_RTYPE: if (funct == FUNCT_JR) pc_next = rs_val;
            default: ;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= STATE_FETCH;
            pc    <= `MIPS_RESET_VECTOR;
        end else begin
            case (state)
                STATE_FETCH: begin
                    if (!waitrequest) state <= STATE_EXECUTE;   // Fetch accepted.
                end
                STATE_EXECUTE: begin
                    pc <= pc_next;
                    if (is_load || is_store) begin
                        state <= STATE_MEMORY;
                    end else if (pc_next == `MIPS_HALT_ADDR) begin
                        state <= STATE_HALTED;
                    end else begin
                        state <= STATE_FETCH;
                    end
                end
                STATE_MEMORY: begin
                    if (!waitrequest) state <= is_load ? STATE_WRITEBACK : STATE_FETCH;
                end
                STATE_WRITEBACK: state <= STATE_FETCH;
                STATE_HALTED:    state <= STATE_HALTED;   // Held until reset.
                default:         state <= STATE_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == STATE_EXECUTE) ir <= readdata;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register file, ALU and bus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign rf_write_en = ((state == STATE_EXECUTE) && exec_write) || (state == STATE_WRITEBACK);
    assign rf_data_in  = (state == STATE_WRITEBACK) ? readdata : alu_result;

    mips_reg_file u_reg_file (
        .clk         (clk),
        .reset       (reset),
        .addr_a      (rs),
        .addr_b      (rt),
        .write_addr  (rd),
        .write_en    (rf_write_en),
        .data_in     (rf_data_in),
        .a           (rs_val),
        .b           (rt_val),
        .register_v0 (register_v0)
    );

    mips_alu u_alu (
        .op     (alu_op),
        .x      (rs_val),
        .y      (alu_y),
        .shamt  (shamt),
        .result (alu_result),
        .zero   (alu_zero)
    );

    assign is_load    = (opcode == OPCODE_LW);
    assign is_store   = (opcode == OPCODE_SW);
    assign read       = (state == STATE_FETCH) || ((state == STATE_MEMORY) && is_load);
    assign write      = (state == STATE_MEMORY) && is_store;
    assign address    = (state == STATE_MEMORY) ? alu_result : pc;   // Data address is the sum.
    assign writedata  = rt_val;
    assign byteenable = 4'b1111;
    assign active     = (state != STATE_HALTED);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_rw_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(read && write)
    );

    // A stalled transfer keeps its request until accepted.
    a_hold_request: assert property (
        @(posedge clk) disable iff (reset)
        ((read || write) && waitrequest) |=> ($stable(address) && $stable(read) && $stable(write))
    );

    a_hold_wdata: assert property (
        @(posedge clk) disable iff (reset)
        (write && waitrequest) |=> $stable(writedata)
    );

    a_halted_quiet: assert property (
        @(posedge clk) disable iff (reset)
        (state == STATE_HALTED) |=> ((state == STATE_HALTED) && !read && !write)
    );

endmodule

// ==== source/mips_defs.svh ====
// MIPS core constants shared by the CPU, register file and package.

`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define MIPS_RESET_VECTOR 32'hBFC0_0000   // First instruction fetch.
`define MIPS_HALT_ADDR    32'h0000_0000   // Jumping here stops the core.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Data and address width.
`define MIPS_WORD_W   32

// Architectural registers, including the hard-wired zero.
`define MIPS_NUM_REGS 32

`endif

// ==== source/mips_pkg.sv ====
// MIPS types shared by the core: words, register indices and decode enums.

`include "mips_defs.svh"

package mips_pkg;

    typedef logic [`MIPS_WORD_W-1:0]             word_t;
    typedef logic [$clog2(`MIPS_NUM_REGS)-1:0]   reg_idx_t;

    // Primary opcode field, bits 31:26.
    typedef enum logic [5:0] {
        OPCODE_RTYPE = 6'h00,
        OPCODE_J     = 6'h02,
        OPCODE_BEQ   = 6'h04,
        OPCODE_BNE   = 6'h05,
        OPCODE_ADDIU = 6'h09,
        OPCODE_SLTIU = 6'h0B,
        OPCODE_ANDI  = 6'h0C,
        OPCODE_ORI   = 6'h0D,
        OPCODE_XORI  = 6'h0E,
        OPCODE_LUI   = 6'h0F,
        OPCODE_LW    = 6'h23,
        OPCODE_SW    = 6'h2B
    } opcode_t;

    // R-type function field, bits 5:0.
    typedef enum logic [5:0] {
        FUNCT_SLL  = 6'h00,
        FUNCT_SRL  = 6'h02,
        FUNCT_SRA  = 6'h03,
        FUNCT_JR   = 6'h08,
        FUNCT_ADDU = 6'h21,
        FUNCT_SUBU = 6'h23,
        FUNCT_AND  = 6'h24,
        FUNCT_OR   = 6'h25,
        FUNCT_XOR  = 6'h26,
        FUNCT_SLT  = 6'h2A,
        FUNCT_SLTU = 6'h2B
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        STATE_FETCH, STATE_EXECUTE, STATE_MEMORY, STATE_WRITEBACK, STATE_HALTED
    } state_t;

endpackage

// ==== source/mips_reg_file.sv ====
// MIPS register file with two combinational read ports and one write port.

`timescale 1ns/10ps
`include "mips_defs.svh"

module mips_reg_file import mips_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t addr_a,
    input  reg_idx_t addr_b,
    input  reg_idx_t write_addr,
    input  logic     write_en,
    input  word_t    data_in,
    output word_t    a,
    output word_t    b,
    output word_t    register_v0
);

    word_t regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (write_addr != '0)) begin
            regs[write_addr] <= data_in;   // $zero is never written.
        end
    end

    // No forwarding; the CPU never reads a register in its write cycle.
    assign a           = regs[addr_a];
    assign b           = regs[addr_b];
    assign register_v0 = regs[2];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Register 0 must still read as zero after any sequence of writes.
    a_zero_reg: assert property (
        @(posedge clk) disable iff (reset)
        (addr_a == '0) |-> (a == '0)
    );

endmodule

// ==== testbench/mips_cpu_bus_tb.sv ====
// Testbench for the multicycle MIPS core with a wait-state Avalon memory and an ISA model.

`timescale 1ns/10ps
`include "mips_defs.svh"

module mips_cpu_bus_tb import mips_pkg::*; ();

    localparam int    NUM_TESTS   = 4;
    localparam int    PROG_LEN    = 40;
    localparam int    BODY_END    = 32;   // Register moves and the final JR follow.
    localparam int    CYCLE_LIMIT = NUM_TESTS * PROG_LEN * 4 * 5;
    localparam word_t DATA_BASE   = 32'h0000_1000;

    logic       clk, reset, active, write, read, waitrequest;
    word_t      register_v0, address, writedata, readdata;
    logic [3:0] byteenable;

    word_t prog [PROG_LEN];
    word_t dmem [64];                     // Data region as the DUT sees it.
    word_t mregs [32];
    word_t mdm [64];                      // Reference model data memory.
    word_t pc_trace[$], v0_trace[$], st_addr[$], st_data[$];
    word_t model_v0, rng_state, hold_addr, hold_wdata;
    logic  hold_rd, hold_wr, in_req, acc_pending;
    int    wait_left, fetch_idx, st_idx, errs, passed, failed;
    int    cycle_count = 0;

    funct_t  r_functs [10] = '{FUNCT_ADDU, FUNCT_SUBU, FUNCT_AND, FUNCT_OR, FUNCT_XOR,
                               FUNCT_SLT, FUNCT_SLTU, FUNCT_SLL, FUNCT_SRL, FUNCT_SRA};
    opcode_t i_opcodes [6] = '{OPCODE_ADDIU, OPCODE_SLTIU, OPCODE_ANDI, OPCODE_ORI,
                               OPCODE_XORI, OPCODE_LUI};

    mips_cpu_bus DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("Timeout: the CPU did not halt within %0d cycles", CYCLE_LIMIT);
        $display("Testbench failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers and compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic word_t next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic word_t fill_word(input int w);
        return (DATA_BASE + 32'(4 * w)) * 32'h9E37_79B1;   // Unique per address.
    endfunction

    function automatic word_t prog_word(input word_t addr);
        word_t off;
        off = (addr - `MIPS_RESET_VECTOR) >> 2;
        return (off < PROG_LEN) ? prog[off[5:0]] : 32'h0000_0000;
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
            errs++;
        end
    endtask

    task automatic check_addr(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is address %h, expected %h", $time, what, got, exp);
            errs++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
            errs++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Program generator and ISA model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Kind bit 0 adds branches and jumps, bit 1 adds loads and stores.
    task automatic gen_program(input int kind);
        word_t    r, q, jaddr;
        reg_idx_t d, s, t;
        int       off, a;
        prog[0] = {OPCODE_LUI, 5'd0, 5'd9, 16'h0000};   // $9 is the data base.
        prog[1] = {OPCODE_ORI, 5'd9, 5'd9, DATA_BASE[15:0]};
        for (int i = 2; i < BODY_END; i++) begin
            r     = next_rand();
            q     = next_rand();
            d     = {2'b00, r[2:0]} + 5'd1;
            s     = {2'b00, r[5:3]} + 5'd1;
            t     = {2'b00, r[8:6]} + 5'd1;
            off   = int'(q[17:16]) % (BODY_END - i);      // Forward only.
            jaddr = `MIPS_RESET_VECTOR + 32'(4 * (i + 1 + off));
            a     = int'(q[31:28]);
            if (kind[0] && (r[11:10] == 2'b11)) begin
                if (r[13]) begin
                    prog[i] = {OPCODE_J, jaddr[27:2]};
                end else begin
                    prog[i] = {r[12] ? OPCODE_BNE : OPCODE_BEQ, s, t, 16'(off)};
                end
            end else if (kind[1] && (r[11:10] == 2'b10)) begin
                prog[i] = {r[12] ? OPCODE_SW : OPCODE_LW, 5'd9, r[12] ? t : d,
                           8'h00, q[5:0], 2'b00};
            end else if (a < 10) begin
                prog[i] = {OPCODE_RTYPE, s, t, d, q[10:6], r_functs[a]};
            end else begin
                prog[i] = {i_opcodes[a - 10], s, d, q[15:0]};
            end
        end
        for (int k = 0; k < 7; k++) begin
            s = (k == 0) ? 5'd1 : 5'(k + 2);               // Show each register in v0.
            prog[BODY_END + k] = {OPCODE_RTYPE, s, 5'd0, 5'd2, 5'd0, FUNCT_ADDU};
        end
        prog[PROG_LEN - 1] = {OPCODE_RTYPE, 5'd0, 15'd0, FUNCT_JR};
    endtask

    task automatic run_model();
        word_t    pc, npc, ins, se, ze, res, ea;
        reg_idx_t rs, rt, dst;
        pc_trace.delete();
        v0_trace.delete();
        st_addr.delete();
        st_data.delete();
        for (int k = 0; k < 32; k++) mregs[k] = '0;
        for (int w = 0; w < 64; w++) mdm[w] = fill_word(w);
        pc = `MIPS_RESET_VECTOR;
        while (pc != `MIPS_HALT_ADDR) begin
            pc_trace.push_back(pc);
            v0_trace.push_back(mregs[2]);
            ins = prog_word(pc);
            rs  = ins[25:21];
            rt  = ins[20:16];
            se  = {{16{ins[15]}}, ins[15:0]};
            ze  = {16'h0000, ins[15:0]};
            ea  = mregs[rs] + se;
            npc = pc + 32'd4;
            dst = rt;
            res = '0;
            case (opcode_t'(ins[31:26]))
                OPCODE_RTYPE: begin
                    dst = ins[15:11];
                    case (funct_t'(ins[5:0]))
                        FUNCT_ADDU: res = mregs[rs] + mregs[rt];
                        FUNCT_SUBU: res = mregs[rs] - mregs[rt];
                        FUNCT_AND:  res = mregs[rs] & mregs[rt];
                        FUNCT_OR:   res = mregs[rs] | mregs[rt];
                        FUNCT_XOR:  res = mregs[rs] ^ mregs[rt];
                        FUNCT_SLT:  res = ($signed(mregs[rs]) < $signed(mregs[rt])) ? 1 : 0;
                        FUNCT_SLTU: res = (mregs[rs] < mregs[rt]) ? 32'd1 : 32'd0;
                        FUNCT_SLL:  res = mregs[rt] << ins[10:6];
                        FUNCT_SRL:  res = mregs[rt] >> ins[10:6];
                        FUNCT_SRA:  res = $signed(mregs[rt]) >>> ins[10:6];
                        FUNCT_JR: begin
                            npc = mregs[rs];
                            dst = '0;
                        end
                        default:    dst = '0;
                    endcase
                end
                OPCODE_J:     npc = {npc[31:28], ins[25:0], 2'b00};
                OPCODE_BEQ:   if (mregs[rs] == mregs[rt]) npc = npc + (se << 2);
                OPCODE_BNE:   if (mregs[rs] != mregs[rt]) npc = npc + (se << 2);
                OPCODE_ADDIU: res = mregs[rs] + se;
                OPCODE_SLTIU: res = (mregs[rs] < se) ? 32'd1 : 32'd0;
                OPCODE_ANDI:  res = mregs[rs] & ze;
                OPCODE_ORI:   res = mregs[rs] | ze;
                OPCODE_XORI:  res = mregs[rs] ^ ze;
                OPCODE_LUI:   res = {ins[15:0], 16'h0000};
                OPCODE_LW:    res = mdm[ea[7:2]];
                OPCODE_SW: begin
                    st_addr.push_back(ea);
                    st_data.push_back(mregs[rt]);
                    mdm[ea[7:2]] = mregs[rt];
                end
                default: ;
            endcase
            // Branches, jumps, stores and no-ops leave the registers alone.
            if (ins[31:26] inside {6'h02, 6'h04, 6'h05, 6'h2B} || !(ins[31:26] inside
                {6'h00, 6'h09, 6'h0B, 6'h0C, 6'h0D, 6'h0E, 6'h0F, 6'h23})) dst = '0;
            if (dst != '0) mregs[dst] = res;
            pc = npc;
        end
        model_v0 = mregs[2];
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Avalon memory model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One bus cycle, run on each falling edge.
    task automatic bus_step();
        if (acc_pending) begin   // Accepted at the last rising edge.
            acc_pending = 1'b0;
            if (hold_wr) begin
                if (st_idx < st_addr.size()) begin
                    check_addr(hold_addr, st_addr[st_idx], "store address");
                    check_word(hold_wdata, st_data[st_idx], "store data");
                end else begin
                    $display("Unexpected extra store to %h at %0t", hold_addr, $time);
                    errs++;
                end
                dmem[hold_addr[7:2]] = hold_wdata;
                st_idx++;
            end else if (hold_addr[31:8] == DATA_BASE[31:8]) begin
                readdata = dmem[hold_addr[7:2]];   // Load data.
            end else begin
                if (fetch_idx == 0) check_addr(hold_addr, `MIPS_RESET_VECTOR, "first fetch");
                if (fetch_idx < pc_trace.size()) begin
                    check_addr(hold_addr, pc_trace[fetch_idx], "fetch address");
                    check_word(register_v0, v0_trace[fetch_idx], "register_v0 at fetch");
                end else begin
                    $display("Unexpected extra fetch from %h at %0t", hold_addr, $time);
                    errs++;
                end
                readdata = prog_word(hold_addr);
                fetch_idx++;
            end
        end
        if (read || write) begin
            if (in_req) begin    // Stalled, nothing may move.
                check_addr(address, hold_addr, "address under waitrequest");
                check_flag(read, hold_rd, "read under waitrequest");
                check_flag(write, hold_wr, "write under waitrequest");
                if (write) check_word(writedata, hold_wdata, "writedata under waitrequest");
            end else begin
                wait_left = int'(next_rand() % 4);
                in_req    = 1'b1;
            end
            check_flag(&byteenable, 1'b1, "byteenable all ones");
            hold_addr  = address;
            hold_wdata = writedata;
            hold_rd    = read;
            hold_wr    = write;
            if (wait_left > 0) begin
                waitrequest = 1'b1;
                wait_left--;
            end else begin
                waitrequest = 1'b0;
                in_req      = 1'b0;
                acc_pending = 1'b1;
            end
        end else begin
            waitrequest = 1'b0;
        end
    endtask

    task automatic run_test(input int n);
        errs = 0;
        gen_program(n % 4);
        run_model();
        for (int w = 0; w < 64; w++) dmem[w] = fill_word(w);
        fetch_idx   = 0;
        st_idx      = 0;
        in_req      = 1'b0;
        acc_pending = 1'b0;
        reset       = 1'b1;
        waitrequest = 1'b0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        check_flag(active, 1'b1, "active after reset");
        check_flag(write, 1'b0, "write after reset");
        check_flag(read, 1'b1, "read after reset");
        while (active) begin
            bus_step();
            @(negedge clk);
        end
        check_word(word_t'(fetch_idx), word_t'(pc_trace.size()), "fetch count");
        check_word(word_t'(st_idx), word_t'(st_addr.size()), "store count");
        check_word(register_v0, model_v0, "final register_v0");
        repeat (20) begin
            @(negedge clk);
            check_flag(active, 1'b0, "active after halt");
            check_flag(read, 1'b0, "read after halt");
            check_flag(write, 1'b0, "write after halt");
        end
        if (errs == 0) passed++;
        else failed++;
        $display("Test %0d (kind %0d): %0d fetches, %0d stores, %0d errors",
                 n, n % 4, fetch_idx, st_idx, errs);
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        reset       = 1'b1;
        waitrequest = 1'b0;
        readdata    = '0;
        rng_state   = 32'h131e_7ad5;
        passed      = 0;
        failed      = 0;
        for (int n = 0; n < NUM_TESTS; n++) begin
            run_test(n);
        end
        $display("Tests passed: %0d, tests failed: %0d", passed, failed);
        if (failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
